// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_dcd
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
   input  logic                  clk,
   input  logic                  rst_n,
   input  io_bus_pkg::cmd_word_t cmd,
   input  logic                  accept,
   output io_cmd_pkg::dec_cmd_t  dec,
   output logic [7:0]            page_addr
);

   always_comb begin
      dec     = '0;
      dec.adr = {page_addr[7:4], cmd.addr[3:0]};   // Page nibble plus offset nibble
      dec.dat = cmd.data;
      case (cmd.comm)
         io_cmd_pkg::CMD_IO_READ: begin
            dec.is_bus = 1'b1;
         end
         io_cmd_pkg::CMD_IO_WRITE: begin
            dec.is_bus = 1'b1;
            dec.we     = 1'b1;
         end
         io_cmd_pkg::CMD_LOAD_PA: begin
            dec.load_pa = accept;
         end
         io_cmd_pkg::CMD_CLR_RTC: begin
            dec.clr_rtc = accept;
         end
         default: begin
            dec.is_bus = 1'b0;   // NOP and unused codes
         end
      endcase
   end

   // Page address register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         page_addr <= '0;
      end else if (dec.load_pa) begin
         page_addr <= cmd.addr;
      end
   end

endmodule

// File: idb_readback.sv
`timescale 1ns/1ps

module idb_readback (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  accept,
   input  io_cmd_pkg::idbs_sel_e idbs,
   input  logic                  rd_done,
   input  logic [7:0]            rd_data,
   input  logic                  timeout,
   input  logic [7:0]            page_addr,
   input  logic [7:0]            rtc_value,
   input  logic                  rt_irq,
   output logic [7:0]            idb_out,
   output logic                  idb_valid
);

   logic [7:0]             rd_data_q;
   logic                   to_flag;
   logic                   sel_hit;
   logic [7:0]             sel_val;
   io_bus_pkg::io_status_t status;

   assign sel_hit = accept && (idbs != io_cmd_pkg::IDBS_NONE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_data_q <= '0;
         to_flag   <= 1'b0;
         idb_valid <= 1'b0;
      end else begin
         if (rd_done) begin
            rd_data_q <= rd_data;
            to_flag   <= 1'b0;   // Good read clears it
         end else if (timeout) begin
            to_flag <= 1'b1;
         end
         idb_valid <= sel_hit;
      end
   end

   always_comb begin
      status         = '0;
      status.tout    = to_flag;
      status.rt_pend = rt_irq;
      case (idbs)
         io_cmd_pkg::IDBS_IODATA: sel_val = rd_data_q;
         io_cmd_pkg::IDBS_PA:     sel_val = page_addr;
         io_cmd_pkg::IDBS_RTC:    sel_val = rtc_value;
         io_cmd_pkg::IDBS_STATUS: sel_val = status;
         default:                 sel_val = 8'h00;
      endcase
   end

   // Sampled before the same command's effects land
   always_ff @(posedge clk) begin
      if (sel_hit) begin
         idb_out <= sel_val;
      end
   end

endmodule

// File: io_bus_pkg.sv
package io_bus_pkg;

   // Divisors and timeout are powers of two
   localparam int UART_DIV   = 8;
   localparam int RT_DIV     = 256;
   localparam int IO_TIMEOUT = 16;

   localparam int UART_W  = $clog2(UART_DIV);
   localparam int PRESC_W = $clog2(RT_DIV);
   localparam int WDOG_W  = $clog2(IO_TIMEOUT);

   // One 22-bit microcode word
   typedef struct packed {
      io_cmd_pkg::comm_op_e  comm;
      io_cmd_pkg::idbs_sel_e idbs;
      logic [7:0]            addr;
      logic [7:0]            data;
   } cmd_word_t;

   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [7:0] adr;
      logic [7:0] dat_w;
   } wb_m_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat_r;
   } wb_s_t;

   typedef struct packed {
      logic [5:0] rsvd;          // Reads as zero
      logic       rt_pend;       // Real-time interrupt pending
      logic       tout;          // I/O bus timeout seen
   } io_status_t;

endpackage

// File: io_cmd_pkg.sv
package io_cmd_pkg;

   // Microcode command field
   typedef enum logic [2:0] {
      CMD_NOP      = 3'd0,
      CMD_IO_READ  = 3'd1,
      CMD_IO_WRITE = 3'd2,
      CMD_LOAD_PA  = 3'd3,
      CMD_CLR_RTC  = 3'd4
   } comm_op_e;

   // Register returned on the internal data bus
   typedef enum logic [2:0] {
      IDBS_NONE   = 3'd0,
      IDBS_IODATA = 3'd1,        // Last I/O read data
      IDBS_PA     = 3'd2,        // Page address register
      IDBS_RTC    = 3'd3,        // Real-time counter
      IDBS_STATUS = 3'd4         // Status byte
   } idbs_sel_e;

   typedef enum logic [1:0] {
      S_IDLE = 2'd0,
      S_BUS  = 2'd1,             // Wishbone cycle in progress
      S_DONE = 2'd2
   } cyc_state_e;

   // Decoded command with load_pa and clr_rtc already qualified by accept
   typedef struct packed {
      logic       is_bus;
      logic       we;
      logic       load_pa;
      logic       clr_rtc;
      logic [7:0] adr;
      logic [7:0] dat;
   } dec_cmd_t;

endpackage

// File: io_cycle_ctrl.sv
`timescale 1ns/1ps

module io_cycle_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cmd_valid,
   input  io_cmd_pkg::dec_cmd_t dec,
   output logic                 accept,
   output logic                 cmd_busy,
   output io_bus_pkg::wb_m_t    wb_m,
   input  io_bus_pkg::wb_s_t    wb_s,
   output logic                 rd_done,
   output logic [7:0]           rd_data,
   output logic                 timeout
);

   io_cmd_pkg::cyc_state_e          state;
   io_cmd_pkg::cyc_state_e          state_nxt;
   logic [io_bus_pkg::WDOG_W-1:0]   wdog;
   logic                            wd_expire;
   logic                            in_bus;
   logic                            we_q;
   logic [7:0]                      adr_q;
   logic [7:0]                      dat_q;

   assign accept    = cmd_valid && (state == io_cmd_pkg::S_IDLE);
   assign in_bus    = (state == io_cmd_pkg::S_BUS);
   assign wd_expire = &wdog;     // Last allowed cycle in S_BUS

   always_comb begin
      state_nxt = state;
      case (state)
         io_cmd_pkg::S_IDLE: begin
            if (accept) begin
               state_nxt = dec.is_bus ? io_cmd_pkg::S_BUS : io_cmd_pkg::S_DONE;
            end
         end
         io_cmd_pkg::S_BUS: begin
            if (wb_s.ack || wd_expire) begin
               state_nxt = io_cmd_pkg::S_DONE;
            end
         end
         default: state_nxt = io_cmd_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= io_cmd_pkg::S_IDLE;
         cmd_busy <= 1'b0;
         wdog     <= '0;
         rd_done  <= 1'b0;
         timeout  <= 1'b0;
      end else begin
         state    <= state_nxt;
         cmd_busy <= (state_nxt != io_cmd_pkg::S_IDLE);
         wdog     <= in_bus ? wdog + 1'b1 : '0;
         rd_done  <= in_bus && wb_s.ack && !we_q;
         timeout  <= in_bus && !wb_s.ack && wd_expire;   // Cycle abandoned
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         adr_q <= dec.adr;
         dat_q <= dec.dat;
         we_q  <= dec.we;
      end
      if (in_bus && wb_s.ack) begin
         rd_data <= wb_s.dat_r;
      end
   end

   always_comb begin
      wb_m.cyc   = in_bus;
      wb_m.stb   = in_bus;
      wb_m.we    = we_q;
      wb_m.adr   = adr_q;
      wb_m.dat_w = dat_q;
   end

   a_stb_in_cyc: assert property (
      @(posedge clk) disable iff (!rst_n) wb_m.stb |-> wb_m.cyc
   ) else $error("stb asserted outside cyc");

   // Address held until the slave acks or the watchdog drops the cycle
   a_adr_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      wb_m.stb && !wb_s.ack |=> !wb_m.stb || $stable(wb_m.adr)
   ) else $error("adr changed while waiting for ack");

endmodule

// File: io_dcd.sv
`timescale 1ns/1ps

module io_dcd (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cmd_valid,
   input  io_bus_pkg::cmd_word_t cmd,
   output logic                  cmd_busy,
   output io_bus_pkg::wb_m_t     wb_m,
   input  io_bus_pkg::wb_s_t     wb_s,
   output logic [7:0]            idb_out,
   output logic                  idb_valid,
   output logic                  uart_tick,
   output logic                  rt_irq
);

   logic                 accept;
   io_cmd_pkg::dec_cmd_t dec;
   logic [7:0]           page_addr;
   logic                 rd_done;
   logic [7:0]           rd_data;
   logic                 timeout;
   logic [7:0]           rtc_value;

   osc_prescaler i_osc_prescaler (
      .clk       (clk),
      .rst_n     (rst_n),
      .clr_rtc   (dec.clr_rtc),
      .uart_tick (uart_tick),
      .rtc_value (rtc_value),
      .rt_irq    (rt_irq)
   );

   cmd_decode i_cmd_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd       (cmd),
      .accept    (accept),
      .dec       (dec),
      .page_addr (page_addr)
   );

   io_cycle_ctrl i_io_cycle_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .dec       (dec),
      .accept    (accept),
      .cmd_busy  (cmd_busy),
      .wb_m      (wb_m),
      .wb_s      (wb_s),
      .rd_done   (rd_done),
      .rd_data   (rd_data),
      .timeout   (timeout)
   );

   idb_readback i_idb_readback (
      .clk       (clk),
      .rst_n     (rst_n),
      .accept    (accept),
      .idbs      (cmd.idbs),
      .rd_done   (rd_done),
      .rd_data   (rd_data),
      .timeout   (timeout),
      .page_addr (page_addr),
      .rtc_value (rtc_value),
      .rt_irq    (rt_irq),
      .idb_out   (idb_out),
      .idb_valid (idb_valid)
   );

endmodule

// File: osc_prescaler.sv
`timescale 1ns/1ps

module osc_prescaler (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       clr_rtc,
   output logic       uart_tick,
   output logic [7:0] rtc_value,
   output logic       rt_irq
);

   logic [io_bus_pkg::PRESC_W-1:0] presc;
   logic                           rt_tick;

   assign rt_tick = &presc;      // Full prescaler wrap

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         presc     <= '0;
         uart_tick <= 1'b0;
      end else begin
         presc     <= presc + 1'b1;
         uart_tick <= &presc[io_bus_pkg::UART_W-1:0];
      end
   end

   // Real-time counter with sticky wrap interrupt
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rtc_value <= '0;
         rt_irq    <= 1'b0;
      end else if (clr_rtc) begin
         rtc_value <= '0;
         rt_irq    <= 1'b0;
      end else if (rt_tick) begin
         rtc_value <= rtc_value + 1'b1;
         if (&rtc_value) begin
            rt_irq <= 1'b1;      // 255 -> 0
         end
      end
   end

   a_uart_tick_single: assert property (
      @(posedge clk) disable iff (!rst_n) uart_tick |=> !uart_tick
   ) else $error("uart_tick high in two consecutive cycles");

endmodule

// File: sim.f
io_cmd_pkg.sv
io_bus_pkg.sv
osc_prescaler.sv
cmd_decode.sv
io_cycle_ctrl.sv
idb_readback.sv
io_dcd.sv
tb_clk_gen.sv
tb_io_dcd.sv

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;    // 20 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #2 rst_n = 1'b1;           // Released with the stimulus offset
   end

endmodule

// File: tb_io_dcd.sv
`timescale 1ns/1ps

module tb_io_dcd;

   // Counter wrap phase plus a generous margin for the bus phases
   localparam int CYCLE_LIMIT = 256 * io_bus_pkg::RT_DIV + 8000;

   logic                  clk;
   logic                  rst_n;
   logic                  cmd_valid;
   io_bus_pkg::cmd_word_t cmd;
   logic                  cmd_busy;
   io_bus_pkg::wb_m_t     wb_m;
   io_bus_pkg::wb_s_t     wb_s;
   logic [7:0]            idb_out;
   logic                  idb_valid;
   logic                  uart_tick;
   logic                  rt_irq;

   logic [31:0] stim_lfsr;
   logic [31:0] wait_lfsr;
   logic [7:0]  slv_mem [256];   // Slave side memory
   logic [7:0]  m_mem [256];     // Reference copy
   logic [7:0]  m_page;
   logic [7:0]  m_rd_data;
   logic        m_tout;
   int          clr_tick;        // Real-time tick index at the last clear
   int          edge_cnt;        // Rising edges since reset release
   int          cycles;
   int          tick_cnt;
   int          last_tick;
   logic [7:0]  exp_q [$];

   tb_clk_gen i_tb_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   io_dcd i_io_dcd (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .cmd_busy  (cmd_busy),
      .wb_m      (wb_m),
      .wb_s      (wb_s),
      .idb_out   (idb_out),
      .idb_valid (idb_valid),
      .uart_tick (uart_tick),
      .rt_irq    (rt_irq)
   );

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [7:0] take_bits(inout logic [31:0] st, input int n);
      logic [7:0] val;
      logic       fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb  = st[31] ^ st[21] ^ st[1] ^ st[0];
         st  = {st[30:0], fb};
         val = {val[6:0], fb};
      end
      return val;
   endfunction

   function automatic logic [7:0] fill_byte(input logic [7:0] a);
      return {a[3:0], a[7:4]} ^ 8'h3C;
   endfunction

   function automatic int rt_ticks();
      return edge_cnt / io_bus_pkg::RT_DIV - clr_tick;
   endfunction

   // Expected IDB value from before the command has any effect
   function automatic logic [7:0] ref_idb(input io_cmd_pkg::idbs_sel_e sel);
      int         ticks;
      logic [7:0] res;
      ticks = rt_ticks();
      case (sel)
         io_cmd_pkg::IDBS_IODATA: res = m_rd_data;
         io_cmd_pkg::IDBS_PA:     res = m_page;
         io_cmd_pkg::IDBS_RTC:    res = ticks[7:0];
         io_cmd_pkg::IDBS_STATUS: res = {6'b0, (ticks >= 256), m_tout};
         default:                 res = 8'h00;
      endcase
      return res;
   endfunction

   function automatic void apply_model(input io_cmd_pkg::comm_op_e op,
                                       input logic [7:0] addr, input logic [7:0] data);
      logic [7:0] adr;
      adr = {m_page[7:4], addr[3:0]};
      case (op)
         io_cmd_pkg::CMD_IO_READ: begin
            if (adr >= 8'hF0) begin
               m_tout = 1'b1;
            end else begin
               m_rd_data = m_mem[adr];
               m_tout    = 1'b0;
            end
         end
         io_cmd_pkg::CMD_IO_WRITE: begin
            if (adr >= 8'hF0) begin
               m_tout = 1'b1;
            end else begin
               m_mem[adr] = data;
            end
         end
         io_cmd_pkg::CMD_LOAD_PA: m_page = addr;
         io_cmd_pkg::CMD_CLR_RTC: clr_tick = (edge_cnt + 1) / io_bus_pkg::RT_DIV;
         default: ;
      endcase
   endfunction

   // Called 2 ns after an edge and returns 2 ns after the accepting edge
   task automatic send_cmd(input io_cmd_pkg::comm_op_e op, input io_cmd_pkg::idbs_sel_e sel,
                           input logic [7:0] addr, input logic [7:0] data);
      while (cmd_busy) begin
         @(posedge clk);
         #2;
      end
      cmd_valid = 1'b1;
      cmd.comm  = op;
      cmd.idbs  = sel;
      cmd.addr  = addr;
      cmd.data  = data;
      if (sel != io_cmd_pkg::IDBS_NONE) begin
         exp_q.push_back(ref_idb(sel));
      end
      apply_model(op, addr, data);
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
   endtask

   // Decoy write that is held only while busy and is never accepted
   task automatic offer_while_busy(input logic [7:0] addr, input logic [7:0] data);
      cmd_valid = 1'b1;
      cmd.comm  = io_cmd_pkg::CMD_IO_WRITE;
      cmd.idbs  = io_cmd_pkg::IDBS_PA;
      cmd.addr  = addr;
      cmd.data  = data;
      while (cmd_busy) begin
         @(posedge clk);
         #2;
      end
      cmd_valid = 1'b0;
   endtask

   task automatic check_rt_irq();
      logic exp_irq;
      exp_irq = (rt_ticks() >= 256);
      assert (rt_irq === exp_irq)
         else report_fail($sformatf("FAIL rt_irq got %h expected %h", rt_irq, exp_irq));
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         edge_cnt <= 0;
         cycles   <= 0;
      end else begin
         edge_cnt <= edge_cnt + 1;
         cycles   <= cycles + 1;
         if (cycles >= CYCLE_LIMIT) begin
            report_fail("Run did not finish within the cycle limit");
         end
      end
   end

   // Wishbone slave with a registered ack after 0 to 3 wait cycles
   initial begin
      logic [1:0] wait_left;
      logic [7:0] draw;
      logic       active;
      wb_s      = '0;
      wait_lfsr = 32'h6f40;
      wait_left = 2'd0;
      active    = 1'b0;
      for (int a = 0; a < 256; a++) begin
         slv_mem[a[7:0]] = fill_byte(a[7:0]);
      end
      forever begin
         @(posedge clk);
         #2;
         if (wb_s.ack) begin
            wb_s.ack = 1'b0;     // Taken by the master at this edge
            active   = 1'b0;
            assert (!wb_m.cyc && !wb_m.stb)
               else report_fail("Bus cycle still open in the cycle after ack");
         end else if (wb_m.cyc && wb_m.stb && wb_m.adr < 8'hF0) begin
            if (!active) begin
               active    = 1'b1;
               draw      = take_bits(wait_lfsr, 2);
               wait_left = draw[1:0];
            end
            if (wait_left == 2'd0) begin
               wb_s.ack   = 1'b1;
               wb_s.dat_r = slv_mem[wb_m.adr];
               if (wb_m.we) begin
                  slv_mem[wb_m.adr] = wb_m.dat_w;
               end
            end else begin
               wait_left = wait_left - 2'd1;
            end
         end else begin
            active = 1'b0;
         end
      end
   end

   always @(negedge clk) begin
      logic [7:0] exp_val;
      if (rst_n && idb_valid) begin
         assert (exp_q.size() > 0)
            else report_fail("idb_valid pulsed without a command that selects a register");
         exp_val = exp_q.pop_front();
         assert (idb_out === exp_val)
            else report_fail($sformatf("FAIL idb_out got %h expected %h", idb_out, exp_val));
      end
   end

   always @(negedge clk) begin
      if (!rst_n) begin
         tick_cnt  = 0;
         last_tick = 0;
      end else if (uart_tick) begin
         if (tick_cnt > 0) begin
            assert (edge_cnt - last_tick == io_bus_pkg::UART_DIV)
               else report_fail($sformatf("FAIL uart_tick spacing %h expected %h",
                                          edge_cnt - last_tick, io_bus_pkg::UART_DIV));
         end
         last_tick = edge_cnt;
         tick_cnt  = tick_cnt + 1;
      end
   end

   initial begin
      logic [7:0] page;
      logic [7:0] off;
      logic [7:0] data;
      cmd_valid = 1'b0;
      cmd       = '0;
      stim_lfsr = 32'h6f40;
      m_page    = 8'h00;
      m_rd_data = 8'h00;
      m_tout    = 1'b0;
      clr_tick  = 0;
      for (int a = 0; a < 256; a++) begin
         m_mem[a[7:0]] = fill_byte(a[7:0]);
      end
      @(posedge rst_n);
      @(posedge clk);
      #2;
      assert (!cmd_busy && !wb_m.cyc && !wb_m.stb && !idb_valid && !uart_tick && !rt_irq)
         else report_fail("Outputs not low after reset");

      repeat (20) begin
         page = take_bits(stim_lfsr, 8) & 8'hEF;    // Upper nibble never F
         off  = take_bits(stim_lfsr, 4);
         data = take_bits(stim_lfsr, 8);
         send_cmd(io_cmd_pkg::CMD_LOAD_PA, io_cmd_pkg::IDBS_PA, page, 8'h00);
         send_cmd(io_cmd_pkg::CMD_IO_WRITE, io_cmd_pkg::IDBS_NONE, off, data);
         send_cmd(io_cmd_pkg::CMD_IO_READ, io_cmd_pkg::IDBS_IODATA, off, 8'h00);
         send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_IODATA, 8'h00, 8'h00);
      end
      repeat (12) begin
         page = take_bits(stim_lfsr, 8) & 8'hEF;
         off  = take_bits(stim_lfsr, 4);
         send_cmd(io_cmd_pkg::CMD_LOAD_PA, io_cmd_pkg::IDBS_NONE, page, 8'h00);
         send_cmd(io_cmd_pkg::CMD_IO_READ, io_cmd_pkg::IDBS_NONE, off, 8'h00);
         send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_IODATA, 8'h00, 8'h00);
      end

      // Page register reads its old value on the loading command
      send_cmd(io_cmd_pkg::CMD_LOAD_PA, io_cmd_pkg::IDBS_PA, 8'h5A, 8'h00);
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_PA, 8'h00, 8'h00);

      // No ack from 0xF0 upward
      send_cmd(io_cmd_pkg::CMD_LOAD_PA, io_cmd_pkg::IDBS_NONE, 8'hF0, 8'h00);
      send_cmd(io_cmd_pkg::CMD_IO_WRITE, io_cmd_pkg::IDBS_STATUS, 8'h07, 8'h11);
      send_cmd(io_cmd_pkg::CMD_IO_READ, io_cmd_pkg::IDBS_NONE, 8'h0C, 8'h00);
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_STATUS, 8'h00, 8'h00);
      send_cmd(io_cmd_pkg::CMD_LOAD_PA, io_cmd_pkg::IDBS_NONE, 8'h30, 8'h00);
      send_cmd(io_cmd_pkg::CMD_IO_READ, io_cmd_pkg::IDBS_STATUS, 8'h02, 8'h00);
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_STATUS, 8'h00, 8'h00);

      // Back-pressure
      data = ~m_mem[8'h34];
      send_cmd(io_cmd_pkg::CMD_IO_WRITE, io_cmd_pkg::IDBS_NONE, 8'h04, data);
      offer_while_busy(8'h04, ~data);
      send_cmd(io_cmd_pkg::CMD_IO_READ, io_cmd_pkg::IDBS_NONE, 8'h04, 8'h00);
      offer_while_busy(8'h09, ~m_mem[8'h39]);
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_IODATA, 8'h00, 8'h00);
      send_cmd(io_cmd_pkg::CMD_IO_READ, io_cmd_pkg::IDBS_NONE, 8'h09, 8'h00);
      offer_while_busy(8'h09, 8'h00);
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_IODATA, 8'h00, 8'h00);

      // Real-time counter wrap
      while (edge_cnt < 256 * io_bus_pkg::RT_DIV + 4) begin
         @(posedge clk);
         #2;
      end
      check_rt_irq();
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_RTC, 8'h00, 8'h00);
      send_cmd(io_cmd_pkg::CMD_CLR_RTC, io_cmd_pkg::IDBS_STATUS, 8'h00, 8'h00);
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_STATUS, 8'h00, 8'h00);
      check_rt_irq();
      send_cmd(io_cmd_pkg::CMD_NOP, io_cmd_pkg::IDBS_RTC, 8'h00, 8'h00);
      @(posedge clk);
      #2;

      assert (tick_cnt > 1) else report_fail("Too few uart_tick pulses seen");
      assert (exp_q.size() == 0) else report_fail("Missing idb_valid pulses at the end");
      $display("TB PASSED");
      $finish;
   end

endmodule
